// File: verilog/lm32_fetch_pkg.sv
////////////////////
// LM32 fetch package
// Widths, reset constants, bus structs and FSM states for the instruction unit
////////////////////

package lm32_fetch_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int PC_WIDTH   = 30;               // Word address, byte address >> 2
    localparam int WORD_WIDTH = 32;               // Wishbone data and byte address

    typedef logic [PC_WIDTH-1:0]   pc_t;          // PC in words
    typedef logic [WORD_WIDTH-1:0] word_t;        // Bus word
    typedef logic [WORD_WIDTH-1:0] inst_t;        // Instruction word

    ////////////////////
    // Reset constants
    ////////////////////

    // Exception base, byte address
    localparam word_t EBA_RESET = 32'h0000_0000;

    // One word below EBA so the first fetch lands on EBA
    localparam pc_t PC_F_RESET = pc_t'(EBA_RESET >> 2) - pc_t'(1);

    ////////////////////
    // Bus and fetch structs
    ////////////////////

    // Master to slave, read only with full word select
    typedef struct packed {
        logic  cyc;                               // Cycle in progress
        logic  stb;                               // Strobe, same as cyc here
        word_t adr;                               // Byte address
    } iwb_req_t;

    // Slave to master
    typedef struct packed {
        word_t dat;                               // Read data
        logic  ack;                               // Normal termination
        logic  err;                               // Error termination
    } iwb_rsp_t;

    // Fetched word with its error status
    typedef struct packed {
        inst_t instruction;
        logic  bus_error;                         // Set if the fetch ended in err
    } fetch_result_t;

    ////////////////////
    // Fetch FSM
    ////////////////////

    typedef enum logic [0:0] {
        IWB_IDLE = 1'b0,                          // No cycle on the bus
        IWB_BUSY = 1'b1                           // Waiting for ack or err
    } iwb_state_e;

endpackage

// File: verilog/lm32_fetch_pc_gen.sv
////////////////////
// Fetch address generator
// Picks the next fetch PC by branch priority and holds the F-stage PC
////////////////////

`timescale 1ns/1ps

module lm32_fetch_pc_gen
    import lm32_fetch_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic stall_f_i,                       // Hold F stage
    input  logic branch_taken_x_i,                // X-stage branch taken
    input  logic branch_taken_m_i,                // M-stage branch taken
    input  pc_t  branch_target_x_i,
    input  pc_t  branch_target_m_i,
    output pc_t  pc_a_o,                          // Next fetch address
    output pc_t  pc_f_o                           // F-stage PC
);

    pc_t pc_a;
    pc_t pc_f;
    pc_t pc_seq;                                  // Sequential successor

    ////////////////////
    // A stage
    ////////////////////

    assign pc_seq = pc_f + pc_t'(1);              // Wraps modulo 2^30

    // Later stage wins, its branch is older in program order
    always_comb
    begin
        if (branch_taken_m_i)
        begin
            pc_a = branch_target_m_i;
        end
        else if (branch_taken_x_i)
        begin
            pc_a = branch_target_x_i;
        end
        else
        begin
            pc_a = pc_seq;                        // Fall through
        end
    end

    ////////////////////
    // F stage
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            pc_f <= PC_F_RESET;                   // First fetch goes to EBA
        end
        else if (!stall_f_i)
        begin
            pc_f <= pc_a;
        end
    end

    assign pc_a_o = pc_a;
    assign pc_f_o = pc_f;

endmodule

// File: verilog/lm32_stage_pipe.sv
////////////////////
// Stage pipe
// D-stage instruction register and the PCs of the D, X, M and W stages
////////////////////

`timescale 1ns/1ps

module lm32_stage_pipe
    import lm32_fetch_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          stall_d_i,          // Hold D stage
    input  logic          stall_x_i,          // Hold X stage
    input  logic          stall_m_i,          // Hold M stage
    input  pc_t           pc_f_i,
    input  fetch_result_t fetch_f_i,          // Word and error flag from F
    output fetch_result_t fetch_d_o,
    output pc_t           pc_d_o,
    output pc_t           pc_x_o,
    output pc_t           pc_m_o,
    output pc_t           pc_w_o
);

    fetch_result_t fetch_d;
    pc_t           pc_d;
    pc_t           pc_x;
    pc_t           pc_m;
    pc_t           pc_w;

    ////////////////////
    // D stage
    ////////////////////

    // Instruction register, loads together with its PC
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            fetch_d <= '0;                        // Clears bus_error too
            pc_d    <= '0;
        end
        else if (!stall_d_i)
        begin
            fetch_d <= fetch_f_i;
            pc_d    <= pc_f_i;
        end
    end

    ////////////////////
    // X, M and W PCs
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            pc_x <= '0;
            pc_m <= '0;
            pc_w <= '0;
        end
        else
        begin
            if (!stall_x_i)
                pc_x <= pc_d;
            if (!stall_m_i)
                pc_m <= pc_x;
            pc_w <= pc_m;                         // W never stalls
        end
    end

    assign fetch_d_o = fetch_d;
    assign pc_d_o    = pc_d;
    assign pc_x_o    = pc_x;
    assign pc_m_o    = pc_m;
    assign pc_w_o    = pc_w;

endmodule

// File: verilog/lm32_iwb_master.sv
////////////////////
// Instruction Wishbone master
// Single-word classic reads, fetched-word register and F-stage error flag
////////////////////

`timescale 1ns/1ps

module lm32_iwb_master
    import lm32_fetch_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          stall_a_i,          // No new fetch while high
    input  logic          branch_taken_i,     // Either branch taken
    input  pc_t           pc_a_i,             // Address to fetch next
    input  iwb_rsp_t      iwb_rsp_i,
    output iwb_req_t      iwb_req_o,
    output fetch_result_t fetch_f_o
);

    iwb_state_e state;
    iwb_state_e state_nxt;
    word_t      adr;                              // Byte address of current read
    inst_t      wb_data_f;                        // Last fetched word
    logic       bus_error_f;
    logic       cycle_start;
    logic       cycle_done;

    ////////////////////
    // FSM
    ////////////////////

    assign cycle_start = (state == IWB_IDLE) && !stall_a_i;
    assign cycle_done  = (state == IWB_BUSY) && (iwb_rsp_i.ack || iwb_rsp_i.err);

    always_comb
    begin
        state_nxt = state;
        case (state)
            IWB_IDLE: if (cycle_start) state_nxt = IWB_BUSY;
            IWB_BUSY: if (cycle_done)  state_nxt = IWB_IDLE;
            default:  state_nxt = IWB_IDLE;
        endcase
    end

    // State and address register, address only moves at cycle start
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state <= IWB_IDLE;
            adr   <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (cycle_start)
                adr <= {pc_a_i, 2'b00};           // Word to byte address
        end
    end

    ////////////////////
    // Fetched word and error flag
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wb_data_f   <= '0;
            bus_error_f <= 1'b0;
        end
        else
        begin
            if (cycle_done)
                wb_data_f <= iwb_rsp_i.dat;       // Captured on ack or err alike
            // Error sticks until a new fetch or a redirect
            if ((state == IWB_BUSY) && iwb_rsp_i.err)
                bus_error_f <= 1'b1;
            else if (cycle_start)
                bus_error_f <= 1'b0;
            else if ((state == IWB_IDLE) && branch_taken_i)
                bus_error_f <= 1'b0;              // Redirect drops stale error
        end
    end

    // Strobe tracks cycle, no wait states from the master side
    assign iwb_req_o.cyc = (state == IWB_BUSY);
    assign iwb_req_o.stb = (state == IWB_BUSY);
    assign iwb_req_o.adr = adr;

    assign fetch_f_o.instruction = wb_data_f;
    assign fetch_f_o.bus_error   = bus_error_f;

endmodule

// File: verilog/lm32_instruction_unit.sv
////////////////////
// LM32 instruction unit
// Fetch PC generation, Wishbone instruction fetch and stage PC pipe
////////////////////

`timescale 1ns/1ps

module lm32_instruction_unit
    import lm32_fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    // Pipeline control
    input  logic  stall_a_i,
    input  logic  stall_f_i,
    input  logic  stall_d_i,
    input  logic  stall_x_i,
    input  logic  stall_m_i,
    input  logic  branch_taken_x_i,
    input  logic  branch_taken_m_i,
    input  pc_t   branch_target_x_i,
    input  pc_t   branch_target_m_i,
    // Wishbone, slave side
    input  word_t i_dat_i,
    input  logic  i_ack_i,
    input  logic  i_err_i,
    // Wishbone, master side
    output word_t i_adr_o,
    output logic  i_cyc_o,
    output logic  i_stb_o,
    // Stage PCs
    output pc_t   pc_f_o,
    output pc_t   pc_d_o,
    output pc_t   pc_x_o,
    output pc_t   pc_m_o,
    output pc_t   pc_w_o,
    // Decode stage
    output inst_t instruction_d_o,
    output logic  bus_error_d_o
);

    pc_t           pc_a;                          // Next fetch address
    pc_t           pc_f;
    logic          branch_taken;                  // Any redirect this cycle
    iwb_req_t      iwb_req;
    iwb_rsp_t      iwb_rsp;
    fetch_result_t fetch_f;
    fetch_result_t fetch_d;

    assign branch_taken = branch_taken_x_i || branch_taken_m_i;

    // Bus ports to struct
    assign iwb_rsp.dat = i_dat_i;
    assign iwb_rsp.ack = i_ack_i;
    assign iwb_rsp.err = i_err_i;

    ////////////////////
    // Fetch path
    ////////////////////

    lm32_fetch_pc_gen lm32_fetch_pc_gen_inst (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .stall_f_i         (stall_f_i),
        .branch_taken_x_i  (branch_taken_x_i),
        .branch_taken_m_i  (branch_taken_m_i),
        .branch_target_x_i (branch_target_x_i),
        .branch_target_m_i (branch_target_m_i),
        .pc_a_o            (pc_a),
        .pc_f_o            (pc_f)
    );

    lm32_iwb_master lm32_iwb_master_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .stall_a_i      (stall_a_i),
        .branch_taken_i (branch_taken),
        .pc_a_i         (pc_a),
        .iwb_rsp_i      (iwb_rsp),
        .iwb_req_o      (iwb_req),
        .fetch_f_o      (fetch_f)
    );

    lm32_stage_pipe lm32_stage_pipe_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .stall_d_i (stall_d_i),
        .stall_x_i (stall_x_i),
        .stall_m_i (stall_m_i),
        .pc_f_i    (pc_f),
        .fetch_f_i (fetch_f),
        .fetch_d_o (fetch_d),
        .pc_d_o    (pc_d_o),
        .pc_x_o    (pc_x_o),
        .pc_m_o    (pc_m_o),
        .pc_w_o    (pc_w_o)
    );

    // Struct to ports
    assign i_adr_o         = iwb_req.adr;
    assign i_cyc_o         = iwb_req.cyc;
    assign i_stb_o         = iwb_req.stb;
    assign pc_f_o          = pc_f;
    assign instruction_d_o = fetch_d.instruction;
    assign bus_error_d_o   = fetch_d.bus_error;

endmodule

// File: bench/lm32_fetch_props.sv
////////////////////
// Fetch bus checks
// Wishbone classic protocol assertions on the instruction master
////////////////////

`timescale 1ns/1ps

module lm32_fetch_props
    import lm32_fetch_pkg::*;
(
    input logic     clk_i,
    input logic     rst_n_i,
    input iwb_req_t req_i,                        // Master request
    input iwb_rsp_t rsp_i                         // Slave response
);

    logic done;                                   // Cycle terminates this edge

    assign done = rsp_i.ack || rsp_i.err;

    // Strobe never differs from cycle
    stb_matches_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i.stb == req_i.cyc)
        else $error("i_stb differs from i_cyc");

    // Open cycle keeps its address until terminated
    adr_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_i.cyc && !done) |=> (req_i.cyc && $stable(req_i.adr)))
        else $error("i_adr moved or i_cyc dropped before ack or err");

    // Single-word read, cycle closes right after termination
    cyc_drops: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_i.cyc && done) |=> !req_i.cyc)
        else $error("i_cyc still high after ack or err");

endmodule

bind lm32_iwb_master lm32_fetch_props lm32_fetch_props_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (iwb_req_o),
    .rsp_i   (iwb_rsp_i)
);

// File: bench/tb_instruction_unit.sv
////////////////////
// Instruction unit testbench
// Acts as pipeline and instruction memory, directed fetch tests
////////////////////

`timescale 1ns/1ps

module tb_instruction_unit
    import lm32_fetch_pkg::*;
();

    localparam word_t DATA_KEY       = 32'hA5C3_0F96;  // Memory data = byte address ^ key
    localparam int    TIMEOUT_CYCLES = 50;

    logic  clk_i;
    logic  rst_n_i;
    logic  stall_a_i, stall_f_i, stall_d_i, stall_x_i, stall_m_i;
    logic  branch_taken_x_i, branch_taken_m_i;
    pc_t   branch_target_x_i, branch_target_m_i;
    word_t i_dat_i  = '0;                         // Driven by the memory model only
    logic  i_ack_i  = 1'b0;
    logic  i_err_i  = 1'b0;
    word_t i_adr_o;
    logic  i_cyc_o, i_stb_o;
    pc_t   pc_f_o, pc_d_o, pc_x_o, pc_m_o, pc_w_o;
    inst_t instruction_d_o;
    logic  bus_error_d_o;

    logic  err_next;                              // Next response is err
    logic  in_cycle = 1'b0;                       // Model has seen this cycle
    int    ack_wait = 0;                          // Cycles left before response
    pc_t   exp_f, exp_d, exp_x, exp_m, exp_w;     // Expected stage PCs
    string test_name     = "none";
    int    check_count   = 0;
    int    error_count   = 0;
    int    timeout_count = 0;

    lm32_instruction_unit lm32_instruction_unit_inst (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;               // 100 ns period
    end

    ////////////////////
    // Memory model
    ////////////////////

    function automatic word_t model_data(input word_t adr);
        return adr ^ DATA_KEY;
    endfunction

    // Responds after a random delay, drops the response one clock later
    always @(negedge clk_i)
    begin
        if (i_ack_i || i_err_i)
        begin
            i_ack_i  = 1'b0;
            i_err_i  = 1'b0;
            in_cycle = 1'b0;
        end
        else if (i_cyc_o)
        begin
            if (!in_cycle)
            begin
                in_cycle = 1'b1;
                ack_wait = $urandom % 5;          // 0 to 4 wait cycles
            end
            if (ack_wait == 0)
            begin
                i_dat_i = model_data(i_adr_o);
                if (err_next)
                    i_err_i = 1'b1;
                else
                    i_ack_i = 1'b1;
            end
            else
                ack_wait--;
        end
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_pc(input string what, input pc_t expected, input pc_t actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED [%s] %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED [%s] %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_inst(input string what, input inst_t expected, input inst_t actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED [%s] %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED [%s] %s: expected %b, actual %b",
                     test_name, what, expected, actual);
        end
    endtask

    ////////////////////
    // Pipeline control
    ////////////////////

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic wait_bus_idle();
        int n;
        n = 0;
        while (i_cyc_o && n < TIMEOUT_CYCLES)
        begin
            @(negedge clk_i);
            n++;
        end
        if (i_cyc_o)
        begin
            timeout_count++;
            $display("[%s] bus never went idle before a fetch", test_name);
            finish_run();
        end
    endtask

    task automatic wait_cycle_end();
        int n;
        n = 0;
        while (i_cyc_o && n < TIMEOUT_CYCLES)
        begin
            @(negedge clk_i);
            n++;
        end
        if (i_cyc_o)
        begin
            timeout_count++;
            $display("[%s] fetch cycle never ended", test_name);
            finish_run();
        end
    endtask

    // One edge with D and M open, X open unless held
    task automatic advance_stages(input logic hold_x);
        stall_d_i = 1'b0;
        stall_x_i = hold_x;
        stall_m_i = 1'b0;
        @(negedge clk_i);
        stall_d_i = 1'b1;
        stall_x_i = 1'b1;
        stall_m_i = 1'b1;
        exp_w = exp_m;                            // W trails M by one clock
        exp_m = exp_x;
        if (!hold_x)
            exp_x = exp_d;
        exp_d = exp_f;
    endtask

    // Fetch one word, then move the pipe one stage
    task automatic fetch_step(input logic br_x, input logic br_m,
                              input pc_t tgt_x, input pc_t tgt_m, input logic hold_x);
        if (br_m)
            exp_f = tgt_m;                        // M branch has priority
        else if (br_x)
            exp_f = tgt_x;
        else
            exp_f = exp_f + pc_t'(1);
        wait_bus_idle();
        stall_a_i         = 1'b0;
        stall_f_i         = 1'b0;
        branch_taken_x_i  = br_x;
        branch_taken_m_i  = br_m;
        branch_target_x_i = tgt_x;
        branch_target_m_i = tgt_m;
        @(negedge clk_i);
        stall_a_i        = 1'b1;
        stall_f_i        = 1'b1;
        branch_taken_x_i = 1'b0;
        branch_taken_m_i = 1'b0;
        check_flag("i_cyc_o at start", 1'b1, i_cyc_o);
        check_flag("i_stb_o at start", 1'b1, i_stb_o);
        check_word("i_adr_o", {exp_f, 2'b00}, i_adr_o);
        check_pc("pc_f_o", exp_f, pc_f_o);
        wait_cycle_end();
        advance_stages(hold_x);
        check_pc("pc_d_o", exp_d, pc_d_o);
        check_pc("pc_x_o", exp_x, pc_x_o);
        check_pc("pc_m_o", exp_m, pc_m_o);
        check_pc("pc_w_o", exp_w, pc_w_o);
        if (!err_next)
            check_inst("instruction_d_o", model_data({exp_d, 2'b00}), instruction_d_o);
        check_flag("bus_error_d_o", err_next, bus_error_d_o);
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_reset_values();
        test_name = "reset";
        check_flag("i_cyc_o", 1'b0, i_cyc_o);
        check_flag("i_stb_o", 1'b0, i_stb_o);
        check_word("i_adr_o", '0, i_adr_o);
        check_pc("pc_f_o", PC_F_RESET, pc_f_o);
        check_pc("pc_d_o", '0, pc_d_o);
        check_pc("pc_x_o", '0, pc_x_o);
        check_pc("pc_m_o", '0, pc_m_o);
        check_pc("pc_w_o", '0, pc_w_o);
        check_inst("instruction_d_o", '0, instruction_d_o);
        check_flag("bus_error_d_o", 1'b0, bus_error_d_o);
    endtask

    task automatic test_sequential_fetch();
        test_name = "sequential";
        repeat (8)
            fetch_step(1'b0, 1'b0, '0, '0, 1'b0); // Starts at EBA
    endtask

    task automatic test_branch_priority();
        test_name = "branch";
        fetch_step(1'b1, 1'b1, 30'h0000_2000, 30'h0000_0100, 1'b0);  // Both, M wins
        fetch_step(1'b0, 1'b0, '0, '0, 1'b0);
        fetch_step(1'b1, 1'b0, 30'h0004_0000, 30'h0000_0300, 1'b0);  // X only
        fetch_step(1'b0, 1'b0, '0, '0, 1'b0);     // Resumes after target
    endtask

    task automatic test_stage_stall();
        pc_t x_before;
        test_name = "stage stall";
        fetch_step(1'b0, 1'b0, '0, '0, 1'b0);
        x_before = exp_x;
        fetch_step(1'b0, 1'b0, '0, '0, 1'b1);     // X held on this advance
        check_pc("pc_x_o frozen", x_before, pc_x_o);
        @(negedge clk_i);
        check_pc("pc_w_o caught up", exp_m, pc_w_o);
        fetch_step(1'b0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic test_bus_error();
        test_name = "bus error";
        err_next = 1'b1;
        fetch_step(1'b0, 1'b0, '0, '0, 1'b0);     // Flag reaches D
        err_next = 1'b0;
        fetch_step(1'b0, 1'b0, '0, '0, 1'b0);     // Clean fetch clears it
    endtask

    initial
    begin
        void'($urandom(85538));
        rst_n_i           = 1'b0;
        stall_a_i         = 1'b1;                 // Pipeline starts frozen
        stall_f_i         = 1'b1;
        stall_d_i         = 1'b1;
        stall_x_i         = 1'b1;
        stall_m_i         = 1'b1;
        branch_taken_x_i  = 1'b0;
        branch_taken_m_i  = 1'b0;
        branch_target_x_i = '0;
        branch_target_m_i = '0;
        err_next          = 1'b0;
        exp_f             = PC_F_RESET;
        exp_d             = '0;
        exp_x             = '0;
        exp_m             = '0;
        exp_w             = '0;
        repeat (10) @(negedge clk_i);
        rst_n_i = 1'b1;
        test_reset_values();
        test_sequential_fetch();
        test_branch_priority();
        test_stage_stall();
        test_bus_error();
        finish_run();
    end

endmodule

// File: files.f
verilog/lm32_fetch_pkg.sv
verilog/lm32_fetch_pc_gen.sv
verilog/lm32_stage_pipe.sv
verilog/lm32_iwb_master.sv
verilog/lm32_instruction_unit.sv
bench/lm32_fetch_props.sv
bench/tb_instruction_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the instruction unit testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_instruction_unit \
    -o tb_instruction_unit \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_instruction_unit > sim.log 2>&1
cat sim.log

grep -q "^TESTBENCH PASSED$" sim.log \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run failed, see sim.log"; exit 1; }
